/* src/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

`define CACHE_WORD_BITS       32
`define CACHE_ADDR_BITS       32
`define CACHE_INDEX_BITS      5     // 32 lines
`define CACHE_OFFSET_BITS     6     // 64-byte lines
`define CACHE_WORDS_PER_LINE  16

// sizes that follow from the ones above
`define CACHE_BYTE_OFF_BITS   2
`define CACHE_WORD_OFF_BITS   (`CACHE_OFFSET_BITS - `CACHE_BYTE_OFF_BITS)
`define CACHE_TAG_BITS        (`CACHE_ADDR_BITS - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)
`define CACHE_LINES           (1 << `CACHE_INDEX_BITS)

`endif

/* src/cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

    // decoded CPU request
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } cpu_op_e;

    // byte address seen as its cache fields
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]      tag;
        logic [`CACHE_INDEX_BITS-1:0]    index;
        logic [`CACHE_WORD_OFF_BITS-1:0] word_off;
        logic [`CACHE_BYTE_OFF_BITS-1:0] byte_off;
    } cache_addr_t;

    // one full line image as it goes into the array
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]                             tag;
        logic [`CACHE_WORDS_PER_LINE-1:0][`CACHE_WORD_BITS-1:0] data;   // word 0 at the low end
        logic                                                   valid;
    } cache_line_t;

endpackage

/* src/mem_bus_pkg.sv */
`include "cache_config.svh"

package mem_bus_pkg;

    // request bundle on the external memory port
    typedef struct packed {
        logic                        re;
        logic                        wr;
        logic [`CACHE_ADDR_BITS-1:0] addr;
        logic [`CACHE_WORD_BITS-1:0] wr_data;
    } mem_req_t;

    typedef enum logic [2:0] {
        MS_IDLE      = 3'd0,
        MS_WRITE     = 3'd1,
        MS_WRITE_FIN = 3'd2,
        MS_READ      = 3'd3,   // first word of a fill outstanding
        MS_READING   = 3'd4,
        MS_READ_FIN  = 3'd5
    } miss_state_e;

endpackage

/* src/cache_lookup.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_lookup (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        re,
    input  logic                        wr,
    input  logic [`CACHE_ADDR_BITS-1:0] addr,
    input  logic                        busy,
    input  logic [`CACHE_TAG_BITS-1:0]  tag_stored,
    input  logic                        valid_stored,
    output cache_pkg::cpu_op_e          op,
    output cache_pkg::cache_addr_t      addr_f,
    output logic                        hit,
    output logic                        hit_ack
);
    import cache_pkg::*;

    logic tag_match;
    logic read_hit_idle;

    always_comb begin
        if (wr) begin
            op = OP_WRITE;   // wr wins when both strobes are up
        end else if (re) begin
            op = OP_READ;
        end else begin
            op = OP_NONE;
        end
    end

    assign addr_f    = cache_addr_t'(addr);
    assign tag_match = (addr_f.tag == tag_stored);
    assign hit       = valid_stored && tag_match;

    // read misses and all writes are acked by the controller
    assign read_hit_idle = (op == OP_READ) && hit && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_ack <= 1'b0;
        end else begin
            hit_ack <= read_hit_idle && !hit_ack;   // re is still held in the ack cycle
        end
    end

    assert property (@(posedge clk) disable iff (rst) hit_ack |=> !hit_ack)
        else $error("hit_ack high for two cycles");

endmodule

/* src/miss_controller.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module miss_controller (
    input  logic                        clk,
    input  logic                        rst,
    input  cache_pkg::cpu_op_e          op,
    input  cache_pkg::cache_addr_t      addr_f,
    input  logic                        hit,
    input  logic [`CACHE_WORD_BITS-1:0] wr_data,
    input  logic [`CACHE_WORD_BITS-1:0] ext_data_in,
    input  logic                        ext_ack,
    output mem_bus_pkg::mem_req_t       mem_req,
    output logic                        fill_valid,
    output cache_pkg::cache_line_t      fill_line,
    output logic                        word_wr_en,
    output logic                        busy,
    output logic                        re_miss_ack,
    output logic                        wr_ack
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    miss_state_e                                            state;
    logic [`CACHE_WORD_OFF_BITS-1:0]                        word_cnt;
    logic [`CACHE_WORDS_PER_LINE-1:0][`CACHE_WORD_BITS-1:0] line_buf;
    logic                                                   req_re;
    logic                                                   req_wr;
    logic [`CACHE_ADDR_BITS-1:0]                            req_addr;
    logic [`CACHE_WORD_BITS-1:0]                            req_wdata;
    logic [`CACHE_ADDR_BITS-1:0]                            line_base;
    logic [`CACHE_ADDR_BITS-1:0]                            word_addr;
    logic                                                   last_word;
    logic                                                   start_read;
    logic                                                   start_write;
    logic                                                   fill_beat;

    assign line_base = {addr_f.tag, addr_f.index, {`CACHE_OFFSET_BITS{1'b0}}};
    assign word_addr = {addr_f.tag, addr_f.index, addr_f.word_off,
                        {`CACHE_BYTE_OFF_BITS{1'b0}}};

    assign last_word   = (int'(word_cnt) == `CACHE_WORDS_PER_LINE - 1);
    assign start_write = (op == OP_WRITE);
    assign start_read  = (op == OP_READ) && !hit && !re_miss_ack;
    assign fill_beat   = ext_ack && ((state == MS_READ) || (state == MS_READING));

    assign mem_req = '{re: req_re, wr: req_wr, addr: req_addr, wr_data: req_wdata};

    assign fill_line = '{tag: addr_f.tag, data: line_buf, valid: 1'b1};

    // the ack cycle after a fill still counts as busy so the hit path stays quiet
    assign busy = (state != MS_IDLE) || re_miss_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= MS_IDLE;
            word_cnt    <= '0;
            req_re      <= 1'b0;
            req_wr      <= 1'b0;
            fill_valid  <= 1'b0;
            word_wr_en  <= 1'b0;
            re_miss_ack <= 1'b0;
            wr_ack      <= 1'b0;
        end else begin
            fill_valid  <= 1'b0;
            word_wr_en  <= 1'b0;
            wr_ack      <= 1'b0;
            re_miss_ack <= fill_valid;   // rd_data holds the filled word by then
            case (state)
                MS_IDLE: begin
                    word_cnt <= '0;
                    if (start_write) begin
                        req_wr <= 1'b1;
                        state  <= MS_WRITE;
                    end else if (start_read) begin
                        req_re <= 1'b1;
                        state  <= MS_READ;
                    end
                end
                MS_WRITE: begin
                    if (ext_ack) begin
                        req_wr     <= 1'b0;
                        wr_ack     <= 1'b1;
                        word_wr_en <= hit;   // a write miss does not allocate
                        state      <= MS_WRITE_FIN;
                    end
                end
                MS_WRITE_FIN: begin
                    state <= MS_IDLE;
                end
                MS_READ, MS_READING: begin
                    if (ext_ack) begin
                        if (last_word) begin
                            req_re     <= 1'b0;
                            fill_valid <= 1'b1;
                            state      <= MS_READ_FIN;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= MS_READING;
                        end
                    end
                end
                MS_READ_FIN: begin
                    state <= MS_IDLE;
                end
                default: begin
                    state <= MS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MS_IDLE) begin
            req_addr  <= start_write ? word_addr : line_base;
            req_wdata <= wr_data;
        end else if (fill_beat) begin
            req_addr <= req_addr + `CACHE_ADDR_BITS'(`CACHE_WORD_BITS / 8);
            line_buf <= {ext_data_in, line_buf[`CACHE_WORDS_PER_LINE-1:1]};
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(mem_req.re && mem_req.wr))
        else $error("external read and write requested together");

    assert property (@(posedge clk) disable iff (rst) fill_valid |-> (state == MS_READ_FIN))
        else $error("line fill outside MS_READ_FIN");

endmodule

/* src/cache_array.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_array (
    input  logic                        clk,
    input  logic                        rst,
    input  cache_pkg::cache_addr_t      addr_f,
    input  logic                        fill_valid,
    input  cache_pkg::cache_line_t      fill_line,
    input  logic                        word_wr_en,
    input  logic [`CACHE_WORD_BITS-1:0] wr_data,
    output logic [`CACHE_TAG_BITS-1:0]  tag_stored,
    output logic                        valid_stored,
    output logic [`CACHE_WORD_BITS-1:0] rd_data
);

    logic [`CACHE_TAG_BITS-1:0]                             tag_mem  [`CACHE_LINES];
    logic [`CACHE_WORDS_PER_LINE-1:0][`CACHE_WORD_BITS-1:0] data_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]                                valid_q;

    // tag and valid of the indexed line go straight back to the lookup
    assign tag_stored   = tag_mem[addr_f.index];
    assign valid_stored = valid_q[addr_f.index];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_valid) begin
            valid_q[addr_f.index] <= fill_line.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_mem[addr_f.index]  <= fill_line.tag;
            data_mem[addr_f.index] <= fill_line.data;
        end else if (word_wr_en) begin
            data_mem[addr_f.index][addr_f.word_off] <= wr_data;
        end
    end

    // on a fill the requested word is taken from the incoming line
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            rd_data <= fill_line.data[addr_f.word_off];
        end else begin
            rd_data <= data_mem[addr_f.index][addr_f.word_off];
        end
    end

endmodule

/* src/cache_top.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        re,
    input  logic                        wr,
    input  logic [`CACHE_ADDR_BITS-1:0] addr,
    input  logic [`CACHE_WORD_BITS-1:0] wr_data,
    output logic [`CACHE_WORD_BITS-1:0] rd_data,
    output logic                        re_ack,
    output logic                        wr_ack,
    output mem_bus_pkg::mem_req_t       mem_req,
    input  logic [`CACHE_WORD_BITS-1:0] ext_data_in,
    input  logic                        ext_ack
);
    import cache_pkg::*;

    cpu_op_e                    op;
    cache_addr_t                addr_f;
    cache_line_t                fill_line;
    logic                       hit;
    logic                       hit_ack;
    logic                       busy;
    logic                       fill_valid;
    logic                       word_wr_en;
    logic                       re_miss_ack;
    logic                       valid_stored;
    logic [`CACHE_TAG_BITS-1:0] tag_stored;

    // hit and miss acks never overlap
    assign re_ack = hit_ack | re_miss_ack;

    cache_lookup u_lookup (
        .clk          (clk),
        .rst          (rst),
        .re           (re),
        .wr           (wr),
        .addr         (addr),
        .busy         (busy),
        .tag_stored   (tag_stored),
        .valid_stored (valid_stored),
        .op           (op),
        .addr_f       (addr_f),
        .hit          (hit),
        .hit_ack      (hit_ack)
    );

    miss_controller u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .addr_f       (addr_f),
        .hit          (hit),
        .wr_data      (wr_data),
        .ext_data_in  (ext_data_in),
        .ext_ack      (ext_ack),
        .mem_req      (mem_req),
        .fill_valid   (fill_valid),
        .fill_line    (fill_line),
        .word_wr_en   (word_wr_en),
        .busy         (busy),
        .re_miss_ack  (re_miss_ack),
        .wr_ack       (wr_ack)
    );

    cache_array u_array (
        .clk          (clk),
        .rst          (rst),
        .addr_f       (addr_f),
        .fill_valid   (fill_valid),
        .fill_line    (fill_line),
        .word_wr_en   (word_wr_en),
        .wr_data      (wr_data),
        .tag_stored   (tag_stored),
        .valid_stored (valid_stored),
        .rd_data      (rd_data)
    );

endmodule

/* test/tb_ext_mem.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_ext_mem (
    input  logic                        clk,
    input  logic                        rst,
    input  mem_bus_pkg::mem_req_t       mem_req,
    output logic [`CACHE_WORD_BITS-1:0] ext_data_in,
    output logic                        ext_ack
);

    // only words written so far are stored, everything else reads the preset pattern
    logic [`CACHE_WORD_BITS-1:0] written [logic [`CACHE_ADDR_BITS-3:0]];
    logic [`CACHE_ADDR_BITS-3:0] word_addr;
    logic [1:0]                  wait_cnt;

    function automatic logic [`CACHE_WORD_BITS-1:0] initial_word(
        input logic [`CACHE_ADDR_BITS-3:0] wa
    );
        return {2'b00, wa} ^ 32'hA5A5_0000;
    endfunction

    assign word_addr = mem_req.addr[`CACHE_ADDR_BITS-1:2];

    // a word is acked once its random wait has run out
    assign ext_ack = !rst && (mem_req.re || mem_req.wr) && (wait_cnt == 2'd0);

    always_comb begin
        if (written.exists(word_addr) != 0) begin
            ext_data_in = written[word_addr];
        end else begin
            ext_data_in = initial_word(word_addr);
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= 2'd0;
        end else if (ext_ack) begin
            wait_cnt <= 2'($urandom % 4);   // 0 to 3 extra cycles for the next word
        end else if ((mem_req.re || mem_req.wr) && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    always @(posedge clk) begin
        if (!rst && ext_ack && mem_req.wr) begin
            written[word_addr] = mem_req.wr_data;
        end
    end

endmodule

/* test/tb_cache.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_cache;
    import mem_bus_pkg::*;

    localparam int CLK_HALF      = 50;
    localparam int CYCLES_PER_OP = 16 * 4 + 10;

    logic                        clk;
    logic                        rst;
    logic                        re;
    logic                        wr;
    logic [`CACHE_ADDR_BITS-1:0] addr;
    logic [`CACHE_WORD_BITS-1:0] wr_data;
    logic [`CACHE_WORD_BITS-1:0] rd_data;
    logic                        re_ack;
    logic                        wr_ack;
    mem_req_t                    mem_req;
    logic [`CACHE_WORD_BITS-1:0] ext_data_in;
    logic                        ext_ack;

    byte unsigned op_q[$];
    logic [31:0]  addr_q[$];
    logic [31:0]  data_q[$];
    logic [31:0]  exp_q[$];
    logic         fill_q[$];
    int           n_ops;
    logic [31:0]  cur_base;
    logic [31:0]  cur_waddr;
    logic [31:0]  cur_wdata;
    int           rd_beats;
    int           wr_beats;
    longint       limit;

    cache_top UUT (
        .clk         (clk),
        .rst         (rst),
        .re          (re),
        .wr          (wr),
        .addr        (addr),
        .wr_data     (wr_data),
        .rd_data     (rd_data),
        .re_ack      (re_ack),
        .wr_ack      (wr_ack),
        .mem_req     (mem_req),
        .ext_data_in (ext_data_in),
        .ext_ack     (ext_ack)
    );

    tb_ext_mem u_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .ext_data_in (ext_data_in),
        .ext_ack     (ext_ack)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        int          fill;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("test/cache_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/cache_golden.txt");
            $display("Done: errors found");
            $fatal(1, "golden file missing");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %d", a, d, e, fill);
            if (n != 4 || (line.getc(0) != "R" && line.getc(0) != "W")) begin
                $display("malformed golden line: %s", line);
                $display("Done: errors found");
                $fatal(1, "bad golden file");
            end
            op_q.push_back(line.getc(0));
            addr_q.push_back(a);
            data_q.push_back(d);
            exp_q.push_back(e);
            fill_q.push_back(fill != 0);
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            $display("golden file holds no operations");
            $display("Done: errors found");
            $fatal(1, "empty golden file");
        end
        n_ops = op_q.size();
    endtask

    // no acks may show up between requests
    task automatic idle_cycle();
        @(posedge clk);
        #1;
        check_value("re_ack", 32'(re_ack), 32'd0);
        check_value("wr_ack", 32'(wr_ack), 32'd0);
    endtask

    task automatic read_word(input logic [31:0] rd_addr, input logic [31:0] expected,
                             input logic fill);
        // fills start at the 64-byte line base
        cur_base = rd_addr & ~32'(`CACHE_WORDS_PER_LINE * (`CACHE_WORD_BITS / 8) - 1);
        rd_beats = 0;
        wr_beats = 0;
        addr     = rd_addr;
        re       = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!re_ack);
        re = 1'b0;
        check_value("rd_data", rd_data, expected);
        check_value("read beats", 32'(rd_beats), fill ? 32'd16 : 32'd0);
        check_value("write beats", 32'(wr_beats), 32'd0);
    endtask

    // addr and wr_data stay put after wr drops while a write hit updates the array
    task automatic write_word(input logic [31:0] w_addr, input logic [31:0] w_data);
        cur_waddr = w_addr;
        cur_wdata = w_data;
        rd_beats  = 0;
        wr_beats  = 0;
        addr      = w_addr;
        wr_data   = w_data;
        wr        = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!wr_ack);
        wr = 1'b0;
        check_value("write beats", 32'(wr_beats), 32'd1);
        check_value("read beats", 32'(rd_beats), 32'd0);
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_value("mem_req.re and mem_req.wr", 32'(mem_req.re && mem_req.wr), 32'd0);
            if (ext_ack && mem_req.re) begin
                check_value("mem_req.addr", mem_req.addr, cur_base + 32'(rd_beats * 4));
                rd_beats++;
            end
            if (ext_ack && mem_req.wr) begin
                check_value("mem_req.addr", mem_req.addr, cur_waddr);
                check_value("mem_req.wr_data", mem_req.wr_data, cur_wdata);
                wr_beats++;
            end
        end
    end

    initial begin
        wait (n_ops > 0);
        limit = (longint'(n_ops) * CYCLES_PER_OP + 20) * 2 * CLK_HALF;
        #(limit);
        $display("run timed out after %0d ns without finishing the golden sequence", limit);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h43c));
        n_ops     = 0;
        rst       = 1'b1;
        re        = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        wr_data   = '0;
        cur_base  = '0;
        cur_waddr = '0;
        cur_wdata = '0;
        rd_beats  = 0;
        wr_beats  = 0;
        load_golden();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("re_ack", 32'(re_ack), 32'd0);
        check_value("wr_ack", 32'(wr_ack), 32'd0);
        check_value("mem_req.re", 32'(mem_req.re), 32'd0);
        check_value("mem_req.wr", 32'(mem_req.wr), 32'd0);
        for (int i = 0; i < n_ops; i++) begin
            if (op_q[i] == "W") begin
                write_word(addr_q[i], data_q[i]);
            end else begin
                read_word(addr_q[i], exp_q[i], fill_q[i]);
            end
            idle_cycle();
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* test/cache_golden.txt */
# op addr wr_data exp_rd fill (op is R or W, values in hex)
# fill is 1 when the read finds its line missing and refills it
R 00000100 00000000 A5A50040 1
R 00000104 00000000 A5A50041 0
R 0000013C 00000000 A5A5004F 0
W 00000108 12345678 00000000 0
R 00000108 00000000 12345678 0
W 00002208 DEADBEEF 00000000 0
R 00002208 00000000 DEADBEEF 1
R 0000220C 00000000 A5A50883 0
R 00000904 00000000 A5A50241 1
R 00000108 00000000 12345678 1
R 00000900 00000000 A5A50240 1
W 00000910 CAFEF00D 00000000 0
R 00000910 00000000 CAFEF00D 0
R 00000110 00000000 A5A50044 1
R 00000914 00000000 A5A50245 1
R 00000910 00000000 CAFEF00D 0
W 00007FFC 0BADCAFE 00000000 0
R 00007FC0 00000000 A5A51FF0 1
R 00007FFC 00000000 0BADCAFE 0
R 12345670 00000000 A128159C 1
R 1234567C 00000000 A128159F 0
W 1234567C 55AA55AA 00000000 0
R 1234567C 00000000 55AA55AA 0
R 00000100 00000000 A5A50040 1

/* vlog.f */
+incdir+src
src/cache_pkg.sv
src/mem_bus_pkg.sv
src/cache_lookup.sv
src/miss_controller.sv
src/cache_array.sv
src/cache_top.sv
test/tb_ext_mem.sv
test/tb_cache.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_cache
FILELIST  := vlog.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
